// ==== hw/bios_ram.sv ====
`timescale 1ns/100ps

module bios_ram
	import pc_bus_pkg::*;
#(
	parameter int BIOS_WORDS = 8192
) (
	input  logic     sys_clk,

	// Request from the router
	input  logic     bios_access,
	input  addr_t    cpu_addr,
	input  word_t    cpu_wdata,
	input  logic     cpu_wr_en,
	input  bytesel_t cpu_bytesel,

	// Response
	output logic     bios_ack,
	output word_t    bios_rdata
);

	localparam int IDX_W = $clog2(BIOS_WORDS);

	// Two byte lanes per word
	logic [1:0][7:0]  mem [BIOS_WORDS];
	logic [IDX_W-1:0] idx;
	logic             start;
	word_t            rd_q;

	// Low word-address bits index the array
	assign idx = cpu_addr[IDX_W:1];

	// First cycle of a request, the ack cycle is skipped
	assign start = bios_access & ~bios_ack;

	// Ack follows the access by one cycle
	// Idle access keeps it low from the first clock
	always_ff @(posedge sys_clk) begin
		bios_ack <= start;
	end

	// Read-before-write port
	always_ff @(posedge sys_clk) begin
		if (start) begin
			rd_q <= mem[idx];
			if (cpu_wr_en && cpu_bytesel[0]) begin
				mem[idx][0] <= cpu_wdata[7:0];
			end
			if (cpu_wr_en && cpu_bytesel[1]) begin
				mem[idx][1] <= cpu_wdata[15:8];
			end
		end
	end

	// Zero outside the ack cycle for the OR merge
	assign bios_rdata = bios_ack ? rd_q : '0;

endmodule

// ==== hw/bus_router.sv ====
`timescale 1ns/100ps

module bus_router
	import pc_bus_pkg::*;
	import pc_map_pkg::*;
(
	input  logic  sys_clk,
	input  logic  xreset,

	// CPU request side
	input  addr_t cpu_addr,
	input  logic  cpu_io,
	input  logic  cpu_access,

	// BIOS window enable from the control register
	input  logic  bios_enabled,

	// Return paths
	input  logic  io_ack,
	input  word_t io_rdata,
	input  logic  bios_ack,
	input  word_t bios_rdata,
	input  logic  ext_ack,
	input  word_t ext_rdata,
	input  logic  vga_ack,
	input  word_t vga_rdata,

	// Target strobes
	output logic  io_access,
	output logic  bios_access,
	output logic  ext_access,
	output logic  vga_access,

	// Merged response to the CPU
	output logic  cpu_ack,
	output word_t cpu_rdata
);

	// ======================================================================
	// Request decode
	// ======================================================================

	logic        mem_access;
	mem_target_t mem_target;

	// I/O and memory split on the CPU space flag
	assign io_access  = cpu_access & cpu_io;
	assign mem_access = cpu_access & ~cpu_io;

	// Disabled BIOS window falls through to SDRAM
	always_comb begin
		if (bios_enabled && (cpu_addr[19:14] == BIOS_TAG)) begin
			mem_target = TGT_BIOS;
		end else if (cpu_addr[19:16] == VGA_TAG) begin
			mem_target = TGT_VGA;
		end else begin
			mem_target = TGT_SDRAM;
		end
	end

	// Purely combinational, no added latency
	assign bios_access = mem_access && (mem_target == TGT_BIOS);
	assign vga_access  = mem_access && (mem_target == TGT_VGA);
	assign ext_access  = mem_access && (mem_target == TGT_SDRAM);

	// ======================================================================
	// Response merge
	// ======================================================================

	// Internal slaves drive zero when idle
	// External ports are masked with their own ack
	assign cpu_ack   = io_ack | bios_ack | ext_ack | vga_ack;
	assign cpu_rdata = io_rdata | bios_rdata
		| (ext_ack ? ext_rdata : '0)
		| (vga_ack ? vga_rdata : '0);

	// Only one target may see a cycle
	a_one_target: assert property (@(posedge sys_clk) disable iff (xreset)
		$onehot0({io_access, bios_access, ext_access, vga_access}));

endmodule

// ==== hw/io_port_decoder.sv ====
`timescale 1ns/100ps

module io_port_decoder
	import pc_bus_pkg::*;
	import pc_map_pkg::*;
(
	input  logic  sys_clk,
	input  logic  xreset,

	// Port number comes from the CPU address
	input  addr_t cpu_addr,
	input  logic  io_access,

	// Device responses
	input  logic  leds_ack,
	input  word_t leds_rdata,
	input  logic  ctrl_ack,
	input  word_t ctrl_rdata,

	// Device selects
	output logic  leds_sel,
	output logic  sdram_cfg_sel,
	output logic  bios_ctrl_sel,

	// Merged I/O response
	output logic  io_ack,
	output word_t io_rdata
);

	logic [14:0] port;
	logic        default_sel;
	logic        default_ack;

	// Word port number
	assign port = cpu_addr[15:1];

	// One compare per mapped port
	assign leds_sel      = io_access && (port == LEDS_PORT);
	assign sdram_cfg_sel = io_access && (port == SDRAM_CFG_PORT);
	assign bios_ctrl_sel = io_access && (port == BIOS_CTRL_PORT);

	// Anything else lands here
	assign default_sel = io_access && !(leds_sel || sdram_cfg_sel || bios_ctrl_sel);

	// Dummy responder for missing devices
	// Same one-cycle timing as a real register
	always_ff @(posedge sys_clk or posedge xreset) begin
		if (xreset) begin
			default_ack <= 1'b0;
		end else begin
			default_ack <= default_sel & ~default_ack;
		end
	end

	// Unmapped reads return zero, so nothing to add
	assign io_ack   = leds_ack | ctrl_ack | default_ack;
	assign io_rdata = leds_rdata | ctrl_rdata;

	// At most one I/O device owns a cycle
	a_sel_onehot: assert property (@(posedge sys_clk) disable iff (xreset)
		$onehot0({leds_sel, sdram_cfg_sel, bios_ctrl_sel, default_sel}));

	// Whichever register answers, acks stay single pulses
	a_ack_pulse: assert property (@(posedge sys_clk) disable iff (xreset)
		io_ack |=> !io_ack);

endmodule

// ==== hw/led_blink_register.sv ====
`timescale 1ns/100ps

module led_blink_register
	import pc_bus_pkg::*;
#(
	parameter int BLINK_CYCLES = 25_000_000,
	parameter int PAUSE_CYCLES = 25_000_000
) (
	input  logic  sys_clk,
	input  logic  xreset,
	input  logic  core_reset,

	// Port access
	input  logic  leds_sel,
	input  word_t cpu_wdata,
	input  logic  cpu_wr_en,

	// Register response
	output logic  leds_ack,
	output word_t leds_rdata,

	// Board LED
	output logic  led_user
);

	localparam int LONGEST = (BLINK_CYCLES > PAUSE_CYCLES) ? BLINK_CYCLES : PAUSE_CYCLES;
	localparam int PHASE_W = $clog2(LONGEST + 1);
	localparam logic [PHASE_W-1:0] BLINK_LAST = PHASE_W'(BLINK_CYCLES - 1);
	localparam logic [PHASE_W-1:0] PAUSE_LAST = PHASE_W'(PAUSE_CYCLES - 1);

	logic [7:0]         count;
	logic [7:0]         mod_cnt;
	logic [PHASE_W-1:0] phase;
	logic               in_pause;
	logic               start;
	logic               wr_hit;
	logic               phase_end;
	logic               seq_idle;
	word_t              rd_q;

	assign start     = leds_sel & ~leds_ack;
	assign wr_hit    = start & cpu_wr_en;
	assign phase_end = phase == (in_pause ? PAUSE_LAST : BLINK_LAST);

	// Sequencer restarts on a write and parks while count is zero
	assign seq_idle = core_reset | wr_hit | (count == '0);

	// ======================================================================
	// Count register
	// ======================================================================

	// Clears itself at the end of the pause
	always_ff @(posedge sys_clk or posedge xreset) begin
		if (xreset) begin
			count <= '0;
		end else if (core_reset) begin
			count <= '0;
		end else if (wr_hit) begin
			count <= cpu_wdata[7:0];
		end else if (in_pause && phase_end) begin
			count <= '0;
		end
	end

	// ======================================================================
	// Blink and pause sequencer
	// ======================================================================

	always_ff @(posedge sys_clk or posedge xreset) begin
		if (xreset) begin
			phase    <= '0;
			mod_cnt  <= '0;
			in_pause <= 1'b0;
			led_user <= 1'b0;
		end else if (seq_idle) begin
			phase    <= '0;
			mod_cnt  <= '0;
			in_pause <= 1'b0;
			led_user <= 1'b0;
		end else begin
			// Lit when the phase is a multiple of the count
			led_user <= ~in_pause & (mod_cnt == '0);
			mod_cnt  <= (mod_cnt == count - 8'd1) ? '0 : mod_cnt + 8'd1;
			if (phase_end) begin
				phase    <= '0;
				in_pause <= ~in_pause;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// ======================================================================
	// Bus response
	// ======================================================================

	always_ff @(posedge sys_clk or posedge xreset) begin
		if (xreset) begin
			leds_ack <= 1'b0;
		end else begin
			leds_ack <= start;
		end
	end

	// Count as it was before the write
	always_ff @(posedge sys_clk) begin
		if (start) begin
			rd_q <= {8'b0, count};
		end
	end

	assign leds_rdata = leds_ack ? rd_q : '0;

endmodule

// ==== hw/pc_bus_pkg.sv ====
package pc_bus_pkg;

	// ======================================================================
	// CPU data bus geometry
	// ======================================================================

	// Word address, bits 19 down to 1
	// Byte address bit 0 is carried by the byte selects
	localparam int ADDR_W = 19;

	// Data word width
	localparam int DATA_W = 16;

	// One select per byte lane
	localparam int LANES = DATA_W / 8;

	// ======================================================================
	// Bus field types
	// ======================================================================

	// Read and write data
	typedef logic [DATA_W-1:0] word_t;

	// Word address, indexed like the byte address
	typedef logic [ADDR_W:1] addr_t;

	// Bit 1 high byte, bit 0 low byte
	typedef logic [LANES-1:0] bytesel_t;

endpackage

// ==== hw/pc_map_pkg.sv ====
package pc_map_pkg;

	// ======================================================================
	// Memory map windows
	// ======================================================================

	// BIOS window 0xFC000 to 0xFFFFF
	// Compared against address bits 19..14
	localparam logic [5:0] BIOS_TAG = 6'b11_1111;

	// VGA window 0xB0000 to 0xBFFFF
	// Compared against address bits 19..16
	localparam logic [3:0] VGA_TAG = 4'hB;

	// Memory cycle destinations
	typedef enum logic [1:0] {
		TGT_SDRAM,
		TGT_VGA,
		TGT_BIOS
	} mem_target_t;

	// ======================================================================
	// I/O ports
	// ======================================================================

	// Word port numbers, i.e. byte port shifted right by one
	// LED blink count, byte port 0x0100
	localparam logic [14:0] LEDS_PORT = 15'h0080;

	// SDRAM configuration status, byte port 0xFFFC
	localparam logic [14:0] SDRAM_CFG_PORT = 15'h7FFE;

	// BIOS enable control, byte port 0xFFF6
	localparam logic [14:0] BIOS_CTRL_PORT = 15'h7FFB;

endpackage

// ==== hw/pc_sys_fabric.sv ====
`timescale 1ns/100ps

module pc_sys_fabric
	import pc_bus_pkg::*;
#(
	parameter int BIOS_WORDS   = 8192,
	parameter int BLINK_CYCLES = 25_000_000,
	parameter int PAUSE_CYCLES = 25_000_000
) (
	input  logic     sys_clk,
	input  logic     xreset,
	input  logic     sdram_config_done,

	// CPU data bus
	input  addr_t    cpu_addr,
	input  word_t    cpu_wdata,
	input  logic     cpu_wr_en,
	input  bytesel_t cpu_bytesel,
	input  logic     cpu_io,
	input  logic     cpu_access,
	output logic     cpu_ack,
	output word_t    cpu_rdata,

	// CPU hold
	output logic     core_reset,

	// SDRAM and VGA window ports
	input  logic     ext_ack,
	input  word_t    ext_rdata,
	input  logic     vga_ack,
	input  word_t    vga_rdata,
	output logic     ext_access,
	output logic     vga_access,
	output addr_t    ext_addr,
	output word_t    ext_wdata,
	output logic     ext_wr_en,
	output bytesel_t ext_bytesel,

	output logic     led_user
);

	logic  io_access;
	logic  io_ack;
	word_t io_rdata;
	logic  bios_access;
	logic  bios_ack;
	word_t bios_rdata;
	logic  bios_enabled;
	logic  leds_sel;
	logic  sdram_cfg_sel;
	logic  bios_ctrl_sel;
	logic  leds_ack;
	word_t leds_rdata;
	logic  ctrl_ack;
	word_t ctrl_rdata;

	// External ports see the CPU fields unchanged
	assign ext_addr    = cpu_addr;
	assign ext_wdata   = cpu_wdata;
	assign ext_wr_en   = cpu_wr_en;
	assign ext_bytesel = cpu_bytesel;

	// ======================================================================
	// Routing
	// ======================================================================

	bus_router i_bus_router (
		.sys_clk, .xreset, .cpu_addr, .cpu_io, .cpu_access, .bios_enabled,
		.io_ack, .io_rdata, .bios_ack, .bios_rdata,
		.ext_ack, .ext_rdata, .vga_ack, .vga_rdata,
		.io_access, .bios_access, .ext_access, .vga_access, .cpu_ack, .cpu_rdata
	);

	io_port_decoder i_io_port_decoder (
		.sys_clk, .xreset, .cpu_addr, .io_access,
		.leds_ack, .leds_rdata, .ctrl_ack, .ctrl_rdata,
		.leds_sel, .sdram_cfg_sel, .bios_ctrl_sel, .io_ack, .io_rdata
	);

	// ======================================================================
	// Slaves
	// ======================================================================

	bios_ram #(.BIOS_WORDS(BIOS_WORDS)) i_bios_ram (
		.sys_clk, .bios_access, .cpu_addr, .cpu_wdata, .cpu_wr_en, .cpu_bytesel,
		.bios_ack, .bios_rdata
	);

	system_control_regs i_system_control_regs (
		.sys_clk, .xreset, .sdram_config_done, .sdram_cfg_sel, .bios_ctrl_sel,
		.cpu_wdata, .cpu_wr_en, .core_reset, .bios_enabled, .ctrl_ack, .ctrl_rdata
	);

	led_blink_register #(
		.BLINK_CYCLES(BLINK_CYCLES),
		.PAUSE_CYCLES(PAUSE_CYCLES)
	) i_led_blink_register (
		.sys_clk, .xreset, .core_reset, .leds_sel, .cpu_wdata, .cpu_wr_en,
		.leds_ack, .leds_rdata, .led_user
	);

endmodule

// ==== hw/system_control_regs.sv ====
`timescale 1ns/100ps

module system_control_regs
	import pc_bus_pkg::*;
(
	input  logic  sys_clk,
	input  logic  xreset,

	// SDRAM controller status
	input  logic  sdram_config_done,

	// Port selects and write data
	input  logic  sdram_cfg_sel,
	input  logic  bios_ctrl_sel,
	input  word_t cpu_wdata,
	input  logic  cpu_wr_en,

	// System state
	output logic  core_reset,
	output logic  bios_enabled,

	// Register response
	output logic  ctrl_ack,
	output word_t ctrl_rdata
);

	logic  any_sel;
	logic  start;
	word_t rd_q;

	// ======================================================================
	// Post-SDRAM reset
	// ======================================================================

	// CPU waits here until the SDRAM is usable
	// Released for good, only xreset brings it back
	always_ff @(posedge sys_clk or posedge xreset) begin
		if (xreset) begin
			core_reset <= 1'b1;
		end else if (sdram_config_done) begin
			core_reset <= 1'b0;
		end
	end

	// ======================================================================
	// Port registers
	// ======================================================================

	assign any_sel = sdram_cfg_sel | bios_ctrl_sel;
	assign start   = any_sel & ~ctrl_ack;

	// Shared single-pulse ack
	always_ff @(posedge sys_clk or posedge xreset) begin
		if (xreset) begin
			ctrl_ack <= 1'b0;
		end else begin
			ctrl_ack <= start;
		end
	end

	// BIOS mapped in after every core reset
	// Bit 0 of a write switches the window
	always_ff @(posedge sys_clk or posedge xreset) begin
		if (xreset) begin
			bios_enabled <= 1'b1;
		end else if (core_reset) begin
			bios_enabled <= 1'b1;
		end else if (start && bios_ctrl_sel && cpu_wr_en) begin
			bios_enabled <= cpu_wdata[0];
		end
	end

	// Read value sampled before any write lands
	// Status port is read only
	always_ff @(posedge sys_clk) begin
		if (start) begin
			rd_q <= {15'b0, sdram_cfg_sel ? sdram_config_done : bios_enabled};
		end
	end

	assign ctrl_rdata = ctrl_ack ? rd_q : '0;

	// CPU is held in reset, so nothing may reach these ports
	a_quiet_in_reset: assert property (@(posedge sys_clk) disable iff (xreset)
		core_reset |-> !any_sel);

endmodule

// ==== sources.f ====
hw/pc_bus_pkg.sv
hw/pc_map_pkg.sv
hw/bus_router.sv
hw/io_port_decoder.sv
hw/bios_ram.sv
hw/system_control_regs.sv
hw/led_blink_register.sv
hw/pc_sys_fabric.sv
verification/pc_sys_fabric_tb.sv

// ==== verification/pc_sys_fabric_tb.sv ====
`timescale 1ns/100ps

module pc_sys_fabric_tb
	import pc_bus_pkg::*;
();

	localparam int BIOS_WORDS   = 8192;
	localparam int BLINK_CYCLES = 64;
	localparam int PAUSE_CYCLES = 32;
	localparam int ACK_TIMEOUT  = 20;

	// Target codes of the reference model
	localparam int T_IO    = 0;
	localparam int T_SDRAM = 1;
	localparam int T_VGA   = 2;
	localparam int T_BIOS  = 3;

	logic     sys_clk;
	logic     xreset;
	logic     sdram_config_done;
	addr_t    cpu_addr;
	word_t    cpu_wdata;
	logic     cpu_wr_en;
	bytesel_t cpu_bytesel;
	logic     cpu_io;
	logic     cpu_access;
	logic     cpu_ack;
	word_t    cpu_rdata;
	logic     core_reset;
	logic     ext_ack;
	word_t    ext_rdata;
	logic     vga_ack;
	word_t    vga_rdata;
	logic     ext_access;
	logic     vga_access;
	addr_t    ext_addr;
	word_t    ext_wdata;
	logic     ext_wr_en;
	bytesel_t ext_bytesel;
	logic     led_user;

	// Reference state
	word_t bios_shadow [BIOS_WORDS];
	logic  bios_en_model = 1'b1;
	int    exp_target = T_IO;
	logic  exp_check = 1'b0;
	word_t exp_rdata = '0;
	int    cycle_cnt = 0;
	logic  led_seen = 1'b0;

	pc_sys_fabric #(
		.BIOS_WORDS(BIOS_WORDS),
		.BLINK_CYCLES(BLINK_CYCLES),
		.PAUSE_CYCLES(PAUSE_CYCLES)
	) i_pc_sys_fabric (.*);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	// Decode on the byte address straight from the memory map
	function automatic int expected_target(input addr_t a, input logic io, input logic bios_en);
		logic [19:0] byte_addr;
		byte_addr = {a, 1'b0};
		if (io)
			return T_IO;
		if (bios_en && byte_addr >= 20'hFC000)
			return T_BIOS;
		if (byte_addr >= 20'hB0000 && byte_addr <= 20'hBFFFF)
			return T_VGA;
		return T_SDRAM;
	endfunction

	// Distinct pattern per external target
	function automatic word_t responder_data(input addr_t a, input int tgt);
		return a[16:1] ^ {a[19:17], 13'h0} ^ ((tgt == T_VGA) ? 16'hC3A5 : 16'h5A3C);
	endfunction

	// Word offset inside the 16 KB BIOS window
	function automatic int window_index(input addr_t a);
		return int'(({a, 1'b0} - 20'hFC000) >> 1);
	endfunction

	function automatic addr_t port_addr(input logic [15:0] byte_port);
		return addr_t'(byte_port >> 1);
	endfunction

	// ======================================================================
	// Error handling
	// ======================================================================

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, actual,
				expected);
			abort_run();
		end
	endtask

	// ======================================================================
	// External responders
	// ======================================================================

	initial begin : sdram_responder
		int delay;
		forever begin
			@(posedge sys_clk);
			if (ext_access) begin
				delay = $urandom_range(0, 4);
				repeat (delay) @(posedge sys_clk);
				@(negedge sys_clk);
				ext_ack   = 1'b1;
				ext_rdata = responder_data(ext_addr, T_SDRAM);
				@(negedge sys_clk);
				ext_ack   = 1'b0;
				ext_rdata = '0;
			end
		end
	end

	initial begin : vga_responder
		int delay;
		forever begin
			@(posedge sys_clk);
			if (vga_access) begin
				delay = $urandom_range(0, 4);
				repeat (delay) @(posedge sys_clk);
				@(negedge sys_clk);
				vga_ack   = 1'b1;
				vga_rdata = responder_data(ext_addr, T_VGA);
				@(negedge sys_clk);
				vga_ack   = 1'b0;
				vga_rdata = '0;
			end
		end
	end

	// ======================================================================
	// Checker and monitors
	// ======================================================================

	// Routing checked on every access cycle and data on the ack cycle
	always @(posedge sys_clk) begin
		if (!xreset && cpu_access) begin
			check_value("ext_access", ext_access, exp_target == T_SDRAM);
			check_value("vga_access", vga_access, exp_target == T_VGA);
			// External ports carry the CPU request unchanged
			if (exp_target == T_SDRAM || exp_target == T_VGA) begin
				check_value("ext_addr", ext_addr, cpu_addr);
				check_value("ext_wdata", ext_wdata, cpu_wdata);
				check_value("ext_wr_en", ext_wr_en, cpu_wr_en);
				check_value("ext_bytesel", ext_bytesel, cpu_bytesel);
			end
			if (cpu_ack && exp_check)
				check_value("cpu_rdata", cpu_rdata, exp_rdata);
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (led_user)
			led_seen <= 1'b1;
	end

	// ======================================================================
	// CPU driver
	// ======================================================================

	task automatic bus_cycle(input logic io, input addr_t addr, input logic wr,
		input word_t wdata, input bytesel_t sel, input logic check_rd,
		input word_t io_expect, output word_t rdata);
		int n;
		int tgt;
		tgt = expected_target(addr, io, bios_en_model);
		@(negedge sys_clk);
		exp_target = tgt;
		exp_check  = check_rd && !wr;
		case (tgt)
			T_SDRAM, T_VGA: exp_rdata = responder_data(addr, tgt);
			T_BIOS:         exp_rdata = bios_shadow[window_index(addr)];
			default:        exp_rdata = io_expect;
		endcase
		cpu_io      = io;
		cpu_addr    = addr;
		cpu_wr_en   = wr;
		cpu_wdata   = wdata;
		cpu_bytesel = sel;
		cpu_access  = 1'b1;
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
			if (n > ACK_TIMEOUT) begin
				$display("No ack within %0d cycles for address %h", ACK_TIMEOUT, addr);
				abort_run();
			end
		end while (!cpu_ack);
		rdata = cpu_rdata;
		// Registered slaves answer one cycle after the access cycle
		if (tgt == T_IO || tgt == T_BIOS)
			check_value("ack_delay", n - 1, 1);
		if (tgt == T_BIOS && wr) begin
			if (sel[0])
				bios_shadow[window_index(addr)][7:0] = wdata[7:0];
			if (sel[1])
				bios_shadow[window_index(addr)][15:8] = wdata[15:8];
		end
		@(negedge sys_clk);
		cpu_access = 1'b0;
	endtask

	task automatic mem_write(input addr_t a, input word_t d, input bytesel_t sel);
		word_t rd;
		bus_cycle(1'b0, a, 1'b1, d, sel, 1'b0, '0, rd);
	endtask

	task automatic mem_read(input addr_t a);
		word_t rd;
		bus_cycle(1'b0, a, 1'b0, '0, 2'b11, 1'b1, '0, rd);
	endtask

	task automatic io_write(input logic [15:0] byte_port, input word_t d);
		word_t rd;
		bus_cycle(1'b1, port_addr(byte_port), 1'b1, d, 2'b11, 1'b0, '0, rd);
	endtask

	task automatic io_read(input logic [15:0] byte_port, input word_t expected);
		word_t rd;
		bus_cycle(1'b1, port_addr(byte_port), 1'b0, '0, 2'b11, 1'b1, expected, rd);
	endtask

	// Read with the value returned instead of checked
	task automatic io_poll(input logic [15:0] byte_port, output word_t rd);
		bus_cycle(1'b1, port_addr(byte_port), 1'b0, '0, 2'b11, 1'b0, '0, rd);
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin : main_seq
		int hold;
		int n;
		int start;
		int count;
		addr_t a;
		word_t rd;
		logic [12:0] used_idx [16];

		void'($urandom(32'h9b2f024c));
		xreset            = 1'b1;
		sdram_config_done = 1'b0;
		cpu_addr          = '0;
		cpu_wdata         = '0;
		cpu_wr_en         = 1'b0;
		cpu_bytesel       = '0;
		cpu_io            = 1'b0;
		cpu_access        = 1'b0;
		ext_ack           = 1'b0;
		ext_rdata         = '0;
		vga_ack           = 1'b0;
		vga_rdata         = '0;
		repeat (8) @(negedge sys_clk);
		xreset = 1'b0;

		// Idle outputs after reset
		@(posedge sys_clk);
		check_value("cpu_ack", cpu_ack, 0);
		check_value("ext_access", ext_access, 0);
		check_value("vga_access", vga_access, 0);
		check_value("led_user", led_user, 0);

		// CPU held until the SDRAM is configured
		hold = $urandom_range(4, 20);
		repeat (hold) begin
			@(posedge sys_clk);
			check_value("core_reset", core_reset, 1);
		end
		@(negedge sys_clk);
		sdram_config_done = 1'b1;
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
			if (n > 4) begin
				$display("core_reset stayed high after sdram_config_done rose");
				abort_run();
			end
		end while (core_reset);
		io_read(16'hFFFC, 16'h0001);

		// Random external traffic with some of it in the VGA window
		for (int i = 0; i < 40; i++) begin
			a = addr_t'($urandom);
			if (i % 4 == 0)
				a[19:16] = 4'hB;
			if ({a, 1'b0} >= 20'hFC000)
				a[18] = 1'b0;
			if ($urandom_range(0, 1))
				mem_write(a, word_t'($urandom), bytesel_t'($urandom_range(1, 3)));
			else
				mem_read(a);
		end

		// BIOS memory with full words first so every read is defined
		for (int i = 0; i < 16; i++) begin
			used_idx[i] = 13'($urandom);
			mem_write({6'h3F, used_idx[i]}, word_t'($urandom), 2'b11);
		end
		for (int i = 0; i < 16; i++)
			mem_write({6'h3F, used_idx[i]}, word_t'($urandom), bytesel_t'($urandom_range(1, 3)));
		for (int i = 0; i < 16; i++)
			mem_read({6'h3F, used_idx[i]});

		// With BIOS disabled the window goes to SDRAM
		io_write(16'hFFF6, 16'h0000);
		bios_en_model = 1'b0;
		io_read(16'hFFF6, 16'h0000);
		for (int i = 0; i < 4; i++) begin
			mem_write({6'h3F, used_idx[i]}, word_t'($urandom), 2'b11);
			mem_read({6'h3F, used_idx[i]});
		end

		// Unmapped port answers with zero
		io_read(16'h0060, 16'h0000);

		// LED blink then self clear
		count = $urandom_range(1, 9);
		led_seen = 1'b0;
		start = cycle_cnt;
		io_write(16'h0100, word_t'(count));
		io_read(16'h0100, word_t'(count));
		do begin
			io_poll(16'h0100, rd);
			if (cycle_cnt - start > BLINK_CYCLES + PAUSE_CYCLES + 8) begin
				$display("LED count did not clear within the blink and pause time");
				abort_run();
			end
			if (rd != 0)
				check_value("leds_count", rd, count);
		end while (rd != 0);
		if (!led_seen) begin
			$display("led_user never went high during the blink phase");
			abort_run();
		end
		repeat (BLINK_CYCLES + PAUSE_CYCLES) begin
			@(posedge sys_clk);
			check_value("led_user", led_user, 0);
		end

		$display("TB PASSED");
		$finish;
	end

endmodule
